// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Widths fixed by RV32I
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    localparam word_t RESET_PC = 32'h0000_0000;

    // Major opcodes
    localparam opcode_t OP_R      = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;

    // funct3 values, shared between R and I forms where the ISA does
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;
    localparam funct3_t F3_LW   = 3'b010;
    localparam funct3_t F3_SW   = 3'b010;
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_JALR = 3'b000;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

endpackage

// ==== rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    // Fetch to decode
    typedef struct packed {
        logic                valid;
        rv_isa_pkg::word_t   pc;
        rv_isa_pkg::word_t   instr;
    } if_id_t;

    // Decode to execute
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::word_t     op_a;
        rv_isa_pkg::word_t     op_b;
        rv_isa_pkg::word_t     store_data;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::alu_op_e   alu_op;
        logic                  reg_we;
        logic                  load;
        logic                  store;
        rv_isa_pkg::word_t     next_pc;
    } id_ex_t;

    // Execute to memory
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::word_t     result;
        rv_isa_pkg::word_t     store_data;
        rv_isa_pkg::reg_addr_t rd;
        logic                  reg_we;
        logic                  load;
        logic                  store;
        rv_isa_pkg::word_t     next_pc;
    } ex_mem_t;

    // Memory to writeback
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::word_t     result;
        rv_isa_pkg::word_t     load_data;
        rv_isa_pkg::reg_addr_t rd;
        logic                  reg_we;
        logic                  load;
        rv_isa_pkg::word_t     next_pc;
    } mem_wb_t;

    // One retired instruction, qualified by retire_valid_o
    typedef struct packed {
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     wdata;
        logic                  we;
    } retire_t;

    typedef enum logic {
        FETCH,
        WAIT_WB
    } fetch_state_e;

endpackage

// ==== rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  rv_isa_pkg::reg_addr_t raddr1_i,
    input  rv_isa_pkg::reg_addr_t raddr2_i,
    output rv_isa_pkg::word_t     rdata1_o,
    output rv_isa_pkg::word_t     rdata2_o,
    input  logic                  we_i,
    input  rv_isa_pkg::reg_addr_t waddr_i,
    input  rv_isa_pkg::word_t     wdata_i
);

    // x0 has no storage
    rv_isa_pkg::word_t regs [31:1];

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Writeback already drops x0 as a destination
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        we_i |-> (waddr_i != '0));

endmodule

// ==== rv_ifu.sv ====
`timescale 1ns/1ns

module rv_ifu (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    pc_wen_i,
    input  rv_isa_pkg::word_t       next_pc_i,
    output rv_isa_pkg::word_t       imem_addr_o,
    input  rv_isa_pkg::word_t       imem_data_i,
    output rv_pipe_pkg::if_id_t     if_id_o
);

    rv_pipe_pkg::fetch_state_e state_q;
    rv_isa_pkg::word_t         pc_q;

    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        // Instruction is latched only on the fetch edge
        if (state_q == rv_pipe_pkg::FETCH) begin
            if_id_o.pc    <= pc_q;
            if_id_o.instr <= imem_data_i;
        end
        if (!rst_n_i) begin
            state_q       <= rv_pipe_pkg::FETCH;
            pc_q          <= rv_isa_pkg::RESET_PC;
            if_id_o.valid <= 1'b0;
        end else begin
            if_id_o.valid <= (state_q == rv_pipe_pkg::FETCH);
            case (state_q)
                rv_pipe_pkg::FETCH: state_q <= rv_pipe_pkg::WAIT_WB;
                rv_pipe_pkg::WAIT_WB: begin
                    // Writeback hands over the next PC
                    if (pc_wen_i) begin
                        pc_q    <= next_pc_i;
                        state_q <= rv_pipe_pkg::FETCH;
                    end
                end
                default: state_q <= rv_pipe_pkg::FETCH;
            endcase
        end
    end

    a_pc_wen_in_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
        pc_wen_i |-> (state_q == rv_pipe_pkg::WAIT_WB));

endmodule

// ==== rv_idu.sv ====
`timescale 1ns/1ns

module rv_idu (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  rv_pipe_pkg::if_id_t     if_id_i,
    output rv_isa_pkg::reg_addr_t   rs1_addr_o,
    output rv_isa_pkg::reg_addr_t   rs2_addr_o,
    input  rv_isa_pkg::word_t       rs1_data_i,
    input  rv_isa_pkg::word_t       rs2_data_i,
    output rv_pipe_pkg::id_ex_t     id_ex_o
);

    rv_isa_pkg::word_t     ins;
    rv_isa_pkg::opcode_t   opcode;
    rv_isa_pkg::funct3_t   funct3;
    rv_isa_pkg::funct7_t   funct7;
    rv_isa_pkg::word_t     imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_isa_pkg::word_t     pc_plus4;
    rv_pipe_pkg::id_ex_t   dec;

    assign ins        = if_id_i.instr;
    assign opcode     = ins[6:0];
    assign funct3     = ins[14:12];
    assign funct7     = ins[31:25];
    assign rs1_addr_o = ins[19:15];
    assign rs2_addr_o = ins[24:20];
    assign pc_plus4   = if_id_i.pc + 32'd4;

    assign imm_i = {{20{ins[31]}}, ins[31:20]};
    assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_u = {ins[31:12], 12'b0};
    assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    always_comb begin
        // Anything not matched below retires as a no-op
        dec            = '0;
        dec.valid      = if_id_i.valid;
        dec.pc         = if_id_i.pc;
        dec.op_a       = rs1_data_i;
        dec.op_b       = imm_i;
        dec.store_data = rs2_data_i;
        dec.rd         = ins[11:7];
        dec.alu_op     = rv_isa_pkg::ALU_ADD;
        dec.next_pc    = pc_plus4;
        case (opcode)
            rv_isa_pkg::OP_R: begin
                dec.op_b   = rs2_data_i;
                dec.reg_we = 1'b1;
                case ({funct7, funct3})
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD}: dec.alu_op = rv_isa_pkg::ALU_ADD;
                    {rv_isa_pkg::F7_SUB,  rv_isa_pkg::F3_ADD}: dec.alu_op = rv_isa_pkg::ALU_SUB;
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_AND}: dec.alu_op = rv_isa_pkg::ALU_AND;
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_OR}:  dec.alu_op = rv_isa_pkg::ALU_OR;
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR}: dec.alu_op = rv_isa_pkg::ALU_XOR;
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLT}: dec.alu_op = rv_isa_pkg::ALU_SLT;
                    default: dec.reg_we = 1'b0;
                endcase
            end
            rv_isa_pkg::OP_IMM: begin
                dec.reg_we = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD: dec.alu_op = rv_isa_pkg::ALU_ADD;
                    rv_isa_pkg::F3_AND: dec.alu_op = rv_isa_pkg::ALU_AND;
                    rv_isa_pkg::F3_OR:  dec.alu_op = rv_isa_pkg::ALU_OR;
                    rv_isa_pkg::F3_XOR: dec.alu_op = rv_isa_pkg::ALU_XOR;
                    default: dec.reg_we = 1'b0;
                endcase
            end
            rv_isa_pkg::OP_LUI: begin
                dec.op_b   = imm_u;
                dec.alu_op = rv_isa_pkg::ALU_PASS_B;
                dec.reg_we = 1'b1;
            end
            rv_isa_pkg::OP_LOAD: begin
                dec.load   = (funct3 == rv_isa_pkg::F3_LW);
                dec.reg_we = (funct3 == rv_isa_pkg::F3_LW);
            end
            rv_isa_pkg::OP_STORE: begin
                dec.op_b  = imm_s;
                dec.store = (funct3 == rv_isa_pkg::F3_SW);
            end
            rv_isa_pkg::OP_BRANCH: begin
                // Only BEQ and BNE, resolved here
                if ((funct3 == rv_isa_pkg::F3_BEQ && rs1_data_i == rs2_data_i) ||
                    (funct3 == rv_isa_pkg::F3_BNE && rs1_data_i != rs2_data_i)) begin
                    dec.next_pc = if_id_i.pc + imm_b;
                end
            end
            rv_isa_pkg::OP_JAL: begin
                dec.op_b    = pc_plus4;
                dec.alu_op  = rv_isa_pkg::ALU_PASS_B;
                dec.reg_we  = 1'b1;
                dec.next_pc = if_id_i.pc + imm_j;
            end
            rv_isa_pkg::OP_JALR: begin
                if (funct3 == rv_isa_pkg::F3_JALR) begin
                    dec.op_b    = pc_plus4;
                    dec.alu_op  = rv_isa_pkg::ALU_PASS_B;
                    dec.reg_we  = 1'b1;
                    dec.next_pc = (rs1_data_i + imm_i) & ~32'd1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (if_id_i.valid) begin
            id_ex_o <= dec;
        end
        if (!rst_n_i) begin
            id_ex_o.valid <= 1'b0;
        end else begin
            id_ex_o.valid <= if_id_i.valid;
        end
    end

endmodule

// ==== rv_exu.sv ====
`timescale 1ns/1ns

module rv_exu (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  rv_pipe_pkg::id_ex_t     id_ex_i,
    output rv_pipe_pkg::ex_mem_t    ex_mem_o
);

    rv_isa_pkg::word_t alu_res;

    // ALU, also forms the load/store address
    always_comb begin
        alu_res = '0;
        case (id_ex_i.alu_op)
            rv_isa_pkg::ALU_ADD:    alu_res = id_ex_i.op_a + id_ex_i.op_b;
            rv_isa_pkg::ALU_SUB:    alu_res = id_ex_i.op_a - id_ex_i.op_b;
            rv_isa_pkg::ALU_AND:    alu_res = id_ex_i.op_a & id_ex_i.op_b;
            rv_isa_pkg::ALU_OR:     alu_res = id_ex_i.op_a | id_ex_i.op_b;
            rv_isa_pkg::ALU_XOR:    alu_res = id_ex_i.op_a ^ id_ex_i.op_b;
            rv_isa_pkg::ALU_SLT: begin
                alu_res = {31'b0, $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
            end
            rv_isa_pkg::ALU_PASS_B: alu_res = id_ex_i.op_b;
            default:                alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (id_ex_i.valid) begin
            ex_mem_o.pc         <= id_ex_i.pc;
            ex_mem_o.result     <= alu_res;
            ex_mem_o.store_data <= id_ex_i.store_data;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.reg_we     <= id_ex_i.reg_we;
            ex_mem_o.load       <= id_ex_i.load;
            ex_mem_o.store      <= id_ex_i.store;
            ex_mem_o.next_pc    <= id_ex_i.next_pc;
        end
        if (!rst_n_i) begin
            ex_mem_o.valid <= 1'b0;
        end else begin
            ex_mem_o.valid <= id_ex_i.valid;
        end
    end

endmodule

// ==== rv_lsu.sv ====
`timescale 1ns/1ns

module rv_lsu (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  rv_pipe_pkg::ex_mem_t    ex_mem_i,
    output rv_isa_pkg::word_t       dmem_addr_o,
    output rv_isa_pkg::word_t       dmem_wdata_o,
    output logic                    dmem_we_o,
    input  rv_isa_pkg::word_t       dmem_rdata_i,
    output rv_pipe_pkg::mem_wb_t    mem_wb_o
);

    assign dmem_addr_o  = ex_mem_i.result;
    assign dmem_wdata_o = ex_mem_i.store_data;
    // Strobe lasts exactly the one cycle ex_mem is valid
    assign dmem_we_o    = ex_mem_i.valid & ex_mem_i.store;

    always_ff @(posedge clk) begin
        if (ex_mem_i.valid) begin
            mem_wb_o.pc        <= ex_mem_i.pc;
            mem_wb_o.result    <= ex_mem_i.result;
            mem_wb_o.load_data <= dmem_rdata_i;
            mem_wb_o.rd        <= ex_mem_i.rd;
            mem_wb_o.reg_we    <= ex_mem_i.reg_we;
            mem_wb_o.load      <= ex_mem_i.load;
            mem_wb_o.next_pc   <= ex_mem_i.next_pc;
        end
        if (!rst_n_i) begin
            mem_wb_o.valid <= 1'b0;
        end else begin
            mem_wb_o.valid <= ex_mem_i.valid;
        end
    end

    a_ld_st_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        ex_mem_i.valid |-> !(ex_mem_i.load && ex_mem_i.store));

    // One instruction in flight, so stores never come back to back
    a_we_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_we_o |=> !dmem_we_o);

endmodule

// ==== rv_wbu.sv ====
`timescale 1ns/1ns

module rv_wbu (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  rv_pipe_pkg::mem_wb_t    mem_wb_i,
    output logic                    rf_we_o,
    output rv_isa_pkg::reg_addr_t   rf_waddr_o,
    output rv_isa_pkg::word_t       rf_wdata_o,
    output logic                    pc_wen_o,
    output rv_isa_pkg::word_t       next_pc_o,
    output logic                    retire_valid_o,
    output rv_pipe_pkg::retire_t    retire_o
);

    // Writes to x0 are dropped here so the retire record shows no write
    assign rf_we_o    = mem_wb_i.valid & mem_wb_i.reg_we & (mem_wb_i.rd != '0);
    assign rf_waddr_o = mem_wb_i.rd;
    assign rf_wdata_o = mem_wb_i.load ? mem_wb_i.load_data : mem_wb_i.result;

    // Release fetch
    assign pc_wen_o   = mem_wb_i.valid;
    assign next_pc_o  = mem_wb_i.next_pc;

    always_ff @(posedge clk) begin
        if (mem_wb_i.valid) begin
            retire_o.pc    <= mem_wb_i.pc;
            retire_o.rd    <= mem_wb_i.rd;
            retire_o.wdata <= rf_wdata_o;
            retire_o.we    <= rf_we_o;
        end
        if (!rst_n_i) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= mem_wb_i.valid;
        end
    end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ns

module rv_core (
    input  logic                    clk,
    input  logic                    rst_n_i,
    output rv_isa_pkg::word_t       imem_addr_o,
    input  rv_isa_pkg::word_t       imem_data_i,
    output rv_isa_pkg::word_t       dmem_addr_o,
    output rv_isa_pkg::word_t       dmem_wdata_o,
    output logic                    dmem_we_o,
    input  rv_isa_pkg::word_t       dmem_rdata_i,
    output logic                    retire_valid_o,
    output rv_pipe_pkg::retire_t    retire_o
);

    // Stage records
    rv_pipe_pkg::if_id_t   if_id;
    rv_pipe_pkg::id_ex_t   id_ex;
    rv_pipe_pkg::ex_mem_t  ex_mem;
    rv_pipe_pkg::mem_wb_t  mem_wb;

    // Register file ports
    rv_isa_pkg::reg_addr_t rs1_addr, rs2_addr, rf_waddr;
    rv_isa_pkg::word_t     rs1_data, rs2_data, rf_wdata;
    logic                  rf_we;

    // Fetch restart from writeback
    logic                  pc_wen;
    rv_isa_pkg::word_t     next_pc;

    rv_regfile u_regfile (
        .clk(clk), .rst_n_i(rst_n_i),
        .raddr1_i(rs1_addr), .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data), .rdata2_o(rs2_data),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
    );

    rv_ifu u_ifu (
        .clk(clk), .rst_n_i(rst_n_i),
        .pc_wen_i(pc_wen), .next_pc_i(next_pc),
        .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i),
        .if_id_o(if_id)
    );

    rv_idu u_idu (
        .clk(clk), .rst_n_i(rst_n_i),
        .if_id_i(if_id),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .id_ex_o(id_ex)
    );

    rv_exu u_exu (
        .clk(clk), .rst_n_i(rst_n_i),
        .id_ex_i(id_ex), .ex_mem_o(ex_mem)
    );

    rv_lsu u_lsu (
        .clk(clk), .rst_n_i(rst_n_i),
        .ex_mem_i(ex_mem),
        .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
        .dmem_we_o(dmem_we_o), .dmem_rdata_i(dmem_rdata_i),
        .mem_wb_o(mem_wb)
    );

    rv_wbu u_wbu (
        .clk(clk), .rst_n_i(rst_n_i),
        .mem_wb_i(mem_wb),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .pc_wen_o(pc_wen), .next_pc_o(next_pc),
        .retire_valid_o(retire_valid_o), .retire_o(retire_o)
    );

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core;

    logic                 clk;
    logic                 rst_n_i;
    rv_isa_pkg::word_t    imem_addr_o, imem_data_i;
    rv_isa_pkg::word_t    dmem_addr_o, dmem_wdata_o, dmem_rdata_i;
    logic                 dmem_we_o;
    logic                 retire_valid_o;
    rv_pipe_pkg::retire_t retire_o;

    rv_isa_pkg::word_t imem [256];
    rv_isa_pkg::word_t dmem [256];
    int                wp;
    rv_isa_pkg::word_t halt_pc;
    logic [31:0]       lfsr_q = 32'hd663;

    // Reference model state
    rv_isa_pkg::word_t model_regs [32];
    rv_isa_pkg::word_t model_dmem [256];
    rv_isa_pkg::word_t model_pc;

    rv_core uut (
        .clk(clk), .rst_n_i(rst_n_i),
        .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i),
        .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
        .dmem_we_o(dmem_we_o), .dmem_rdata_i(dmem_rdata_i),
        .retire_valid_o(retire_valid_o), .retire_o(retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Word-addressed memories with combinational read
    assign imem_data_i  = imem[imem_addr_o[9:2]];
    assign dmem_rdata_i = dmem[dmem_addr_o[9:2]];

    always @(posedge clk) begin
        if (dmem_we_o) begin
            dmem[dmem_addr_o[9:2]] <= dmem_wdata_o;
        end
    end

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic rv_isa_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_R};
    endfunction

    function automatic rv_isa_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_isa_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, rv_isa_pkg::F3_SW, imm[4:0], rv_isa_pkg::OP_STORE};
    endfunction

    function automatic rv_isa_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OP_BRANCH};
    endfunction

    function automatic rv_isa_pkg::word_t enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_isa_pkg::OP_LUI};
    endfunction

    function automatic rv_isa_pkg::word_t enc_jal(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OP_JAL};
    endfunction

    function automatic rv_isa_pkg::word_t r_alu(input logic [2:0] sel, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2);
        case (sel)
            3'd0: return enc_r(rv_isa_pkg::F7_BASE, rs2, rs1, rv_isa_pkg::F3_ADD, rd);
            3'd1: return enc_r(rv_isa_pkg::F7_SUB, rs2, rs1, rv_isa_pkg::F3_ADD, rd);
            3'd2: return enc_r(rv_isa_pkg::F7_BASE, rs2, rs1, rv_isa_pkg::F3_AND, rd);
            3'd3: return enc_r(rv_isa_pkg::F7_BASE, rs2, rs1, rv_isa_pkg::F3_OR, rd);
            3'd4: return enc_r(rv_isa_pkg::F7_BASE, rs2, rs1, rv_isa_pkg::F3_XOR, rd);
            default: return enc_r(rv_isa_pkg::F7_BASE, rs2, rs1, rv_isa_pkg::F3_SLT, rd);
        endcase
    endfunction

    function automatic rv_isa_pkg::word_t i_alu(input logic [1:0] sel, input logic [11:0] imm,
            input logic [4:0] rs1, input logic [4:0] rd);
        rv_isa_pkg::funct3_t f3;
        case (sel)
            2'd0: f3 = rv_isa_pkg::F3_ADD;
            2'd1: f3 = rv_isa_pkg::F3_AND;
            2'd2: f3 = rv_isa_pkg::F3_OR;
            default: f3 = rv_isa_pkg::F3_XOR;
        endcase
        return enc_i(imm, rs1, f3, rd, rv_isa_pkg::OP_IMM);
    endfunction

    // Branches and jumps only go forward, so the program always reaches the end
    function automatic rv_isa_pkg::word_t rand_instr(input rv_isa_pkg::word_t pc);
        logic [4:0] rd, rs1, rs2;
        logic [2:0] kind;
        rd   = 5'(rand_bits(5));
        rs1  = 5'(rand_bits(5));
        rs2  = 5'(rand_bits(5));
        kind = 3'(rand_bits(3));
        case (kind)
            3'd0: return r_alu(3'(rand_bits(3)), rd, rs1, rs2);
            3'd1: return i_alu(2'(rand_bits(2)), 12'(rand_bits(12)), rs1, rd);
            3'd2: return enc_lui(20'(rand_bits(20)), rd);
            3'd3: return enc_s({2'b00, 8'(rand_bits(8)), 2'b00}, rs2, 5'd0);
            3'd4: begin
                return enc_i({2'b00, 8'(rand_bits(8)), 2'b00}, 5'd0, rv_isa_pkg::F3_LW, rd,
                             rv_isa_pkg::OP_LOAD);
            end
            3'd5: begin
                return enc_b(rand_bits(1) ? 13'd8 : 13'd4, rs2, rs1,
                             rand_bits(1) ? rv_isa_pkg::F3_BNE : rv_isa_pkg::F3_BEQ);
            end
            3'd6: begin
                if (rand_bits(1) != 0) begin
                    return enc_jal(21'd8, rd);
                end
                // Odd target checks that bit 0 is cleared
                return enc_i(12'(pc + 32'd8 + rand_bits(1)), 5'd0, rv_isa_pkg::F3_JALR, rd,
                             rv_isa_pkg::OP_JALR);
            end
            default: return {25'(rand_bits(25)), 7'b0001011};
        endcase
    endfunction

    task automatic emit(input rv_isa_pkg::word_t ins);
        imem[wp] = ins;
        wp++;
    endtask

    task automatic build_program();
        rv_isa_pkg::word_t filler;
        filler = enc_i(12'd1, 5'd0, rv_isa_pkg::F3_ADD, 5'd31, rv_isa_pkg::OP_IMM);
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_i(12'(i), 5'd0, rv_isa_pkg::F3_ADD, 5'd0, rv_isa_pkg::OP_IMM);
            dmem[i] = 32'h5a00_0000 ^ (32'(i) * 32'h0001_0203);
            model_dmem[i] = dmem[i];
        end
        wp = 0;
        for (int r = 1; r <= 6; r++) begin
            emit(enc_lui(20'(rand_bits(20)), 5'(r)));
            emit(enc_i(12'(rand_bits(12)), 5'(r), rv_isa_pkg::F3_ADD, 5'(r), rv_isa_pkg::OP_IMM));
        end
        // Signed compare against a negative value
        emit(enc_lui(20'h80000, 5'd9));
        emit(enc_r(rv_isa_pkg::F7_BASE, 5'd1, 5'd9, rv_isa_pkg::F3_SLT, 5'd10));
        emit(enc_r(rv_isa_pkg::F7_BASE, 5'd9, 5'd1, rv_isa_pkg::F3_SLT, 5'd11));
        for (int k = 0; k < 3; k++) begin
            emit(r_alu(3'(rand_bits(3)), 5'(rand_bits(5)), 5'(rand_bits(4)), 5'(rand_bits(4))));
            emit(i_alu(2'(rand_bits(2)), 12'(rand_bits(12)), 5'(rand_bits(4)), 5'(rand_bits(5))));
        end
        // x0 as destination, then as source
        emit(enc_i(12'd5, 5'd1, rv_isa_pkg::F3_ADD, 5'd0, rv_isa_pkg::OP_IMM));
        emit(enc_r(rv_isa_pkg::F7_BASE, 5'd2, 5'd1, rv_isa_pkg::F3_ADD, 5'd0));
        emit(enc_r(rv_isa_pkg::F7_BASE, 5'd1, 5'd0, rv_isa_pkg::F3_ADD, 5'd12));
        emit(enc_r(rv_isa_pkg::F7_BASE, 5'd0, 5'd0, rv_isa_pkg::F3_OR, 5'd13));
        for (int k = 0; k < 3; k++) begin
            logic [11:0] addr;
            addr = {2'b00, 8'(rand_bits(8)), 2'b00};
            emit(enc_s(addr, 5'(k + 1), 5'd0));
            emit(enc_i(addr, 5'd0, rv_isa_pkg::F3_LW, 5'(k + 20), rv_isa_pkg::OP_LOAD));
        end
        emit(enc_b(13'd8, 5'd0, 5'd0, rv_isa_pkg::F3_BEQ));
        emit(filler);
        emit(enc_b(13'd8, 5'd0, 5'd0, rv_isa_pkg::F3_BNE));
        emit(filler);
        emit(enc_jal(21'd8, 5'd5));
        emit(filler);
        emit(enc_i(12'(wp * 4 + 9), 5'd0, rv_isa_pkg::F3_JALR, 5'd6, rv_isa_pkg::OP_JALR));
        emit(filler);
        // x5 holds a nonzero link address here
        emit(enc_b(13'd8, 5'd0, 5'd5, rv_isa_pkg::F3_BEQ));
        emit(filler);
        emit(enc_b(13'd8, 5'd0, 5'd5, rv_isa_pkg::F3_BNE));
        emit(filler);
        // Encodings outside the supported set
        emit(32'hffff_ffff);
        emit(enc_i(12'd3, 5'd1, 3'b001, 5'd14, rv_isa_pkg::OP_IMM));
        emit(enc_r(7'b0000001, 5'd2, 5'd1, rv_isa_pkg::F3_ADD, 5'd15));
        for (int k = 0; k < 200; k++) begin
            emit(rand_instr(32'(wp * 4)));
        end
        emit(enc_i(12'd0, 5'd0, rv_isa_pkg::F3_ADD, 5'd0, rv_isa_pkg::OP_IMM));
        halt_pc = 32'(wp * 4);
        emit(enc_jal(21'd0, 5'd0));
    endtask

    // Executes the instruction at model_pc and returns its retire record
    function automatic rv_pipe_pkg::retire_t model_step();
        rv_isa_pkg::word_t     ins, a, b, imm_i, val, npc, addr;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::funct3_t   f3;
        logic                  we;
        rv_pipe_pkg::retire_t  ret;
        ins   = imem[model_pc[9:2]];
        rd    = ins[11:7];
        f3    = ins[14:12];
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        npc   = model_pc + 32'd4;
        val   = '0;
        we    = 1'b0;
        case (rv_isa_pkg::opcode_t'(ins[6:0]))
            rv_isa_pkg::OP_R: begin
                we = 1'b1;
                if (ins[31:25] == rv_isa_pkg::F7_SUB && f3 == rv_isa_pkg::F3_ADD) begin
                    val = a - b;
                end else if (ins[31:25] != rv_isa_pkg::F7_BASE) begin
                    we = 1'b0;
                end else begin
                    case (f3)
                        rv_isa_pkg::F3_ADD: val = a + b;
                        rv_isa_pkg::F3_AND: val = a & b;
                        rv_isa_pkg::F3_OR:  val = a | b;
                        rv_isa_pkg::F3_XOR: val = a ^ b;
                        rv_isa_pkg::F3_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: we = 1'b0;
                    endcase
                end
            end
            rv_isa_pkg::OP_IMM: begin
                we = 1'b1;
                case (f3)
                    rv_isa_pkg::F3_ADD: val = a + imm_i;
                    rv_isa_pkg::F3_AND: val = a & imm_i;
                    rv_isa_pkg::F3_OR:  val = a | imm_i;
                    rv_isa_pkg::F3_XOR: val = a ^ imm_i;
                    default: we = 1'b0;
                endcase
            end
            rv_isa_pkg::OP_LUI: begin
                val = {ins[31:12], 12'b0};
                we  = 1'b1;
            end
            rv_isa_pkg::OP_LOAD: begin
                addr = a + imm_i;
                val  = model_dmem[addr[9:2]];
                we   = (f3 == rv_isa_pkg::F3_LW);
            end
            rv_isa_pkg::OP_STORE: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                if (f3 == rv_isa_pkg::F3_SW) begin
                    model_dmem[addr[9:2]] = b;
                end
            end
            rv_isa_pkg::OP_BRANCH: begin
                if ((f3 == rv_isa_pkg::F3_BEQ && a == b) ||
                    (f3 == rv_isa_pkg::F3_BNE && a != b)) begin
                    npc = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            rv_isa_pkg::OP_JAL: begin
                val = model_pc + 32'd4;
                we  = 1'b1;
                npc = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            rv_isa_pkg::OP_JALR: begin
                if (f3 == rv_isa_pkg::F3_JALR) begin
                    val = model_pc + 32'd4;
                    we  = 1'b1;
                    npc = (a + imm_i) & ~32'd1;
                end
            end
            default: ;
        endcase
        // x0 never reports a write
        if (rd == '0) begin
            we = 1'b0;
        end
        if (we) begin
            model_regs[rd] = val;
        end
        ret.pc    = model_pc;
        ret.rd    = rd;
        ret.wdata = val;
        ret.we    = we;
        model_pc  = npc;
        return ret;
    endfunction

    // The store in flight belongs to the instruction at model_pc
    task automatic check_store();
        rv_isa_pkg::word_t ins, addr;
        ins  = imem[model_pc[9:2]];
        addr = model_regs[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        check_value("dmem_we_o opcode", 32'(ins[6:0]), 32'(rv_isa_pkg::OP_STORE));
        check_value("dmem_addr_o", dmem_addr_o, addr);
        check_value("dmem_wdata_o", dmem_wdata_o, model_regs[ins[24:20]]);
    endtask

    always @(negedge clk) begin
        if (rst_n_i && dmem_we_o) begin
            check_store();
        end
    end

    task automatic wait_retire(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!retire_valid_o && cycles < 100);
        if (!retire_valid_o) begin
            $display("no instruction retired within 100 cycles");
            stop_run();
        end
    endtask

    initial begin
        rv_pipe_pkg::retire_t exp;
        int                   gap;
        int                   count;
        rst_n_i = 1'b0;
        build_program();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc = rv_isa_pkg::RESET_PC;
        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;
        count   = 0;
        while (model_pc != halt_pc) begin
            wait_retire(gap);
            if (count > 0) begin
                check_value("retire_gap", 32'(gap), 32'd5);
            end
            exp = model_step();
            check_value("retire_o.pc", retire_o.pc, exp.pc);
            check_value("retire_o.we", 32'(retire_o.we), 32'(exp.we));
            check_value("retire_o.rd", 32'(retire_o.rd), 32'(exp.rd));
            if (exp.we) begin
                check_value("retire_o.wdata", retire_o.wdata, exp.wdata);
            end
            count++;
            if (count > 300) begin
                $display("program did not reach its final instruction");
                stop_run();
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== rv_core.f ====
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_regfile.sv
rv_ifu.sv
rv_idu.sv
rv_exu.sv
rv_lsu.sv
rv_wbu.sv
rv_core.sv
tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
